// ==== dv/operand_addressing_stim.txt ====
# test valid addr io_ready wr_addr wr_data wr_thread expect, all hex except test
# One line per clock, line n runs in thread n mod 4, io_ready serves the read one line up
1 0 000 0 000 000000000 0 000
1 1 005 0 000 000000000 0 005
1 1 123 0 000 000000000 0 123
1 1 3ff 0 000 000000000 0 3ff
2 1 200 0 800 000000010 1 200
2 1 3f5 0 800 0000003f0 3 005
2 1 100 0 000 000000000 0 100
2 1 020 0 000 000000000 0 010
3 1 3f8 0 811 000000200 2 3f8
3 1 3fb 0 821 000030000 2 3fb
3 1 3f9 0 813 000000050 0 3f9
3 1 3fa 0 823 0000e0000 0 3fa
4 1 3f3 0 000 000000000 0 050
4 0 000 1 000 000000000 0 000
4 1 3f1 0 000 000000000 0 200
4 0 000 0 000 000000000 0 000
4 1 3f3 0 000 000000000 0 04e
4 0 000 0 000 000000000 0 000
4 1 3f1 0 000 000000000 0 200
4 0 000 1 000 000000000 0 000
4 1 3f3 0 000 000000000 0 04e
4 0 000 0 000 000000000 0 000
4 1 3f1 0 000 000000000 0 203
5 0 000 0 812 a5c35fd55 1 000
5 0 000 0 822 a5c35fd55 1 000
5 1 3f2 0 000 000000000 0 155
5 0 000 1 812 000000077 1 000
5 0 000 0 000 000000000 0 000
5 0 000 0 000 000000000 0 000
5 1 3f2 0 000 000000000 0 077
6 1 3f1 1 000 000000000 0 203
6 1 3f9 1 000 000000000 0 3f9
6 1 3f3 0 000 000000000 0 04e
6 1 3f2 0 000 000000000 0 07c
6 1 3f1 0 000 000000000 0 206
6 1 3f6 0 000 000000000 0 3e6

// ==== operand_addressing.f ====
rtl/addressing_pkg.sv
rtl/offset_write_if.sv
rtl/addressing_map.sv
rtl/offset_tables.sv
rtl/address_offsetter.sv
rtl/operand_addressing.sv
dv/operand_addressing_tb.sv

// ==== Makefile ====
# Verilator build and run of the operand addressing testbench

TOP       ?= operand_addressing_tb
FILELIST  ?= operand_addressing.f
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/operand_addressing_tb.sv ====
// Testbench for the operand addressing stage, replaying per-cycle stimulus from a file

`timescale 1ns/1ns
`default_nettype none

module operand_addressing_tb import addressing_pkg::*; ();

    localparam int    CLK_PERIOD = 40;
    localparam string STIM_FILE  = "dv/operand_addressing_stim.txt";

    logic       clock;
    logic       arst_n;
    logic       in_valid;
    addr_t      addr_in;
    logic       io_ready;
    wr_addr_t   alu_write_addr;
    word_t      alu_write_data;
    logic [1:0] alu_wr_thread;
    addr_t      addr_out;
    logic       out_valid;

    // One entry per stim line, and each line is one clock cycle
    int         test_q[$];
    logic       valid_q[$];
    addr_t      addr_q[$];
    logic       ready_q[$];
    wr_addr_t   wr_addr_q[$];
    word_t      wr_data_q[$];
    logic [1:0] wr_thread_q[$];
    addr_t      expect_q[$];

    int line_count;
    bit stim_ready;
    int error_count;
    int check_count;
    int test_errors;
    int test_checks;
    int tests_done;

    operand_addressing operand_addressing_i (
        .clock(clock), .arst_n(arst_n), .in_valid(in_valid), .addr_in(addr_in),
        .io_ready(io_ready), .alu_write_addr(alu_write_addr),
        .alu_write_data(alu_write_data), .alu_wr_thread(alu_wr_thread),
        .addr_out(addr_out), .out_valid(out_valid)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // --------------------
    // Stimulus file

    task automatic load_stim();
        int         fd;
        int         fields;
        string      text;
        int         t;
        logic       v;
        addr_t      a;
        logic       r;
        wr_addr_t   wa;
        word_t      wd;
        logic [1:0] wt;
        addr_t      e;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the stim file %s", STIM_FILE);
            error_count++;
        end else begin
            while ($fgets(text, fd) > 0) begin
                fields = $sscanf(text, "%d %h %h %h %h %h %h %h", t, v, a, r, wa, wd, wt, e);
                // Comment lines and blank lines give no fields at all
                if (fields == 8) begin
                    test_q.push_back(t);
                    valid_q.push_back(v);
                    addr_q.push_back(a);
                    ready_q.push_back(r);
                    wr_addr_q.push_back(wa);
                    wr_data_q.push_back(wd);
                    wr_thread_q.push_back(wt);
                    expect_q.push_back(e);
                end else if (fields > 0) begin
                    $display("malformed stim line: %s", text);
                    error_count++;
                end
            end
            $fclose(fd);
        end
        line_count = test_q.size();
        stim_ready = 1'b1;
    endtask

    // --------------------
    // Driver and checker

    task automatic drive_line(input int n);
        if (n < line_count) begin
            in_valid       = valid_q[n];
            addr_in        = addr_q[n];
            io_ready       = ready_q[n];
            alu_write_addr = wr_addr_q[n];
            alu_write_data = wr_data_q[n];
            alu_wr_thread  = wr_thread_q[n];
        end else begin
            in_valid       = 1'b0;
            addr_in        = '0;
            io_ready       = 1'b0;
            alu_write_addr = '0;
            alu_write_data = '0;
            alu_wr_thread  = '0;
        end
    endtask

    task automatic check_output(input logic exp_valid, input addr_t exp_addr);
        check_count++;
        test_checks++;
        if (out_valid !== exp_valid) begin
            $display("mismatch at %0t: out_valid expected %b actual %b",
                     $time, exp_valid, out_valid);
            error_count++;
            test_errors++;
        end else if (exp_valid && (addr_out !== exp_addr)) begin
            $display("mismatch at %0t: addr_out expected %h actual %h",
                     $time, exp_addr, addr_out);
            error_count++;
            test_errors++;
        end
    endtask

    // A test ends with its last stim line
    task automatic report_test(input int n);
        if ((n == line_count - 1) || (test_q[n + 1] != test_q[n])) begin
            $display("test %0d %s, %0d checks, %0d errors", test_q[n],
                     (test_errors == 0) ? "passed" : "failed", test_checks, test_errors);
            tests_done++;
            test_checks = 0;
            test_errors = 0;
        end
    endtask

    initial begin
        clock          = 1'b0;
        arst_n         = 1'b0;
        in_valid       = 1'b0;
        addr_in        = '0;
        io_ready       = 1'b0;
        alu_write_addr = '0;
        alu_write_data = '0;
        alu_wr_thread  = '0;
        load_stim();
        repeat (3) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        for (int k = 0; k < line_count + 2; k++) begin
            if (k > 0) begin
                @(negedge clock);
            end
            // Line k-2 was driven two cycles back, so its result is settled now
            if (k >= 2) begin
                check_output(valid_q[k - 2], expect_q[k - 2]);
                report_test(k - 2);
            end else begin
                check_output(1'b0, '0);
            end
            drive_line(k);
        end
        $display("%0d tests, %0d checks, %0d errors", tests_done, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Four clock periods per stim line, with room for reset and the drain cycles
    initial begin
        wait (stim_ready);
        #((line_count + 8) * CLK_PERIOD * 4);
        $display("timeout: the run did not finish %0d stim lines in time", line_count);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/operand_addressing.sv ====
// Operand addressing stage top level for one A/B memory read port

`timescale 1ns/1ns
`default_nettype none

module operand_addressing import addressing_pkg::*; #(
    parameter  int       THREAD_COUNT    = 4,
    parameter  int       INITIAL_THREAD  = 0,
    parameter  int       PO_COUNT        = 4,
    parameter  addr_t    PO_READ_BASE    = 10'h3F0,
    parameter  addr_t    IO_READ_BASE    = 10'h3F8,
    parameter  int       IO_COUNT        = 4,
    parameter  wr_addr_t DO_WRITE_ADDR   = 12'h800,
    parameter  wr_addr_t PO_WRITE_BASE   = 12'h810,
    parameter  wr_addr_t INC_WRITE_BASE  = 12'h820,
    parameter  int       PO_WORD_OFFSET  = 0,
    parameter  int       INC_WORD_OFFSET = 16,
    parameter  int       DO_WORD_OFFSET  = 0,
    localparam int       THREAD_W        = (THREAD_COUNT > 1) ? $clog2(THREAD_COUNT) : 1,
    localparam int       SLOT_W          = (PO_COUNT > 1) ? $clog2(PO_COUNT) : 1
) (
    input  wire                 clock,
    input  wire                 arst_n,
    input  wire                 in_valid,
    input  wire addr_t          addr_in,
    input  wire                 io_ready,
    input  wire wr_addr_t       alu_write_addr,
    input  wire word_t          alu_write_data,
    input  wire [THREAD_W-1:0]  alu_wr_thread,
    output addr_t               addr_out,
    output logic                out_valid
);

    logic                hit_indirect;
    logic                hit_io;
    logic [SLOT_W-1:0]   po_index;
    logic [THREAD_W-1:0] rd_thread;
    logic [SLOT_W-1:0]   rd_index;
    offset_t             do_value;
    offset_t             po_value;
    increment_t          inc_value;
    logic                inc_en;
    logic [THREAD_W-1:0] inc_thread;
    logic [SLOT_W-1:0]   inc_index;

    offset_write_if #(.THREAD_COUNT(THREAD_COUNT), .PO_COUNT(PO_COUNT)) wr_bus ();

    addressing_map #(
        .THREAD_COUNT(THREAD_COUNT), .PO_COUNT(PO_COUNT),
        .PO_READ_BASE(PO_READ_BASE), .IO_READ_BASE(IO_READ_BASE), .IO_COUNT(IO_COUNT),
        .DO_WRITE_ADDR(DO_WRITE_ADDR), .PO_WRITE_BASE(PO_WRITE_BASE),
        .INC_WRITE_BASE(INC_WRITE_BASE), .PO_WORD_OFFSET(PO_WORD_OFFSET),
        .INC_WORD_OFFSET(INC_WORD_OFFSET), .DO_WORD_OFFSET(DO_WORD_OFFSET)
    ) addressing_map_i (
        .clock(clock), .arst_n(arst_n), .addr_in(addr_in),
        .alu_write_addr(alu_write_addr), .alu_write_data(alu_write_data),
        .alu_wr_thread(alu_wr_thread), .hit_indirect(hit_indirect), .hit_io(hit_io),
        .po_index(po_index), .wr(wr_bus.src)
    );

    offset_tables #(.THREAD_COUNT(THREAD_COUNT), .PO_COUNT(PO_COUNT)) offset_tables_i (
        .clock(clock), .arst_n(arst_n), .wr(wr_bus.dst),
        .rd_thread(rd_thread), .rd_index(rd_index),
        .do_value(do_value), .po_value(po_value), .inc_value(inc_value),
        .inc_en(inc_en), .inc_thread(inc_thread), .inc_index(inc_index)
    );

    address_offsetter #(
        .THREAD_COUNT(THREAD_COUNT), .INITIAL_THREAD(INITIAL_THREAD), .PO_COUNT(PO_COUNT)
    ) address_offsetter_i (
        .clock(clock), .arst_n(arst_n), .in_valid(in_valid), .addr_in(addr_in),
        .hit_indirect(hit_indirect), .hit_io(hit_io), .po_index(po_index),
        .io_ready(io_ready), .rd_thread(rd_thread), .rd_index(rd_index),
        .do_value(do_value), .po_value(po_value), .inc_value(inc_value),
        .inc_en(inc_en), .inc_thread(inc_thread), .inc_index(inc_index),
        .addr_out(addr_out), .out_valid(out_valid)
    );

endmodule

`default_nettype wire

// ==== rtl/address_offsetter.sv ====
// Thread rotation and the two-stage pipeline that applies the per-thread offset

`timescale 1ns/1ns
`default_nettype none

module address_offsetter import addressing_pkg::*; #(
    parameter  int THREAD_COUNT   = 4,
    parameter  int INITIAL_THREAD = 0,
    parameter  int PO_COUNT       = 4,
    localparam int THREAD_W       = (THREAD_COUNT > 1) ? $clog2(THREAD_COUNT) : 1,
    localparam int SLOT_W         = (PO_COUNT > 1) ? $clog2(PO_COUNT) : 1
) (
    input  wire                 clock,
    input  wire                 arst_n,

    input  wire                 in_valid,
    input  wire addr_t          addr_in,

    // Window decode, aligned with stage 2
    input  wire                 hit_indirect,
    input  wire                 hit_io,
    input  wire [SLOT_W-1:0]    po_index,
    input  wire                 io_ready,

    // Table lookup
    output logic [THREAD_W-1:0] rd_thread,
    output logic [SLOT_W-1:0]   rd_index,
    input  wire offset_t        do_value,
    input  wire offset_t        po_value,
    input  wire increment_t     inc_value,

    // Post-increment request
    output logic                inc_en,
    output logic [THREAD_W-1:0] inc_thread,
    output logic [SLOT_W-1:0]   inc_index,

    output addr_t               addr_out,
    output logic                out_valid
);

    logic [THREAD_W-1:0] thread_q;
    logic                s1_valid;
    addr_t               s1_addr;
    logic [THREAD_W-1:0] s1_thread;
    offset_kind_e        kind;
    addr_t               result;

    // Round-robin thread slot, advancing whether or not the slot is issued
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            thread_q <= THREAD_W'(INITIAL_THREAD);
        end else if (thread_q == THREAD_W'(THREAD_COUNT - 1)) begin
            thread_q <= '0;
        end else begin
            thread_q <= thread_q + 1'b1;
        end
    end

    // --------------------
    // Stage 1

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        s1_addr   <= addr_in;
        s1_thread <= thread_q;
    end

    // --------------------
    // Stage 2

    assign rd_thread = s1_thread;
    assign rd_index  = po_index;

    // Shared I/O wins, though the windows should never overlap
    always_comb begin
        if (hit_io) begin
            kind = kind_shared;
        end else if (hit_indirect) begin
            kind = kind_indirect;
        end else begin
            kind = kind_default;
        end
    end

    always_comb begin
        case (kind)
            kind_shared:   result = s1_addr;
            kind_indirect: result = po_value;
            default:       result = s1_addr + do_value;
        endcase
    end

    // A zero increment would leave the pointer as it is, so skip the request
    assign inc_en     = s1_valid && (kind == kind_indirect) && io_ready && (inc_value != '0);
    assign inc_thread = s1_thread;
    assign inc_index  = po_index;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        addr_out <= result;
    end

endmodule

`default_nettype wire

// ==== rtl/offset_tables.sv ====
// Per-thread default offsets, programmed offsets and increments with post-increment

`timescale 1ns/1ns
`default_nettype none

module offset_tables import addressing_pkg::*; #(
    parameter  int THREAD_COUNT = 4,
    parameter  int PO_COUNT     = 4,
    localparam int THREAD_W     = (THREAD_COUNT > 1) ? $clog2(THREAD_COUNT) : 1,
    localparam int SLOT_W       = (PO_COUNT > 1) ? $clog2(PO_COUNT) : 1
) (
    input  wire                 clock,
    input  wire                 arst_n,

    // ALU writes, committed at the next edge
    offset_write_if.dst         wr,

    // Combinational read port for stage 2
    input  wire [THREAD_W-1:0]  rd_thread,
    input  wire [SLOT_W-1:0]    rd_index,
    output offset_t             do_value,
    output offset_t             po_value,
    output increment_t          inc_value,

    // Post-increment request from stage 2
    input  wire                 inc_en,
    input  wire [THREAD_W-1:0]  inc_thread,
    input  wire [SLOT_W-1:0]    inc_index
);

    offset_t    do_q  [THREAD_COUNT];
    offset_t    po_q  [THREAD_COUNT][PO_COUNT];
    increment_t inc_q [THREAD_COUNT][PO_COUNT];

    // Increment of the entry being advanced, widened to offset width
    increment_t inc_sel;
    offset_t    inc_ext;

    assign inc_sel = inc_q[inc_thread][inc_index];
    assign inc_ext = {{(OFFSET_WIDTH-INC_WIDTH){inc_sel[INC_WIDTH-1]}}, inc_sel};

    // --------------------
    // Table update

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int t = 0; t < THREAD_COUNT; t++) begin
                do_q[t] <= '0;
                for (int s = 0; s < PO_COUNT; s++) begin
                    po_q[t][s]  <= '0;
                    inc_q[t][s] <= '0;
                end
            end
        end else begin
            for (int t = 0; t < THREAD_COUNT; t++) begin
                if (wr.wren_do && (wr.wr_thread == THREAD_W'(t))) begin
                    do_q[t] <= wr.do_data;
                end

                for (int s = 0; s < PO_COUNT; s++) begin
                    // The ALU write takes priority over a pending post-increment
                    if (wr.wren_po[s] && (wr.wr_thread == THREAD_W'(t))) begin
                        po_q[t][s] <= wr.po_data;
                    end else if (inc_en && (inc_thread == THREAD_W'(t))
                                 && (inc_index == SLOT_W'(s))) begin
                        po_q[t][s] <= po_q[t][s] + inc_ext;
                    end

                    if (wr.wren_inc[s] && (wr.wr_thread == THREAD_W'(t))) begin
                        inc_q[t][s] <= wr.inc_data;
                    end
                end
            end
        end
    end

    // --------------------
    // Read port

    // Writes from the previous edge are already visible here
    assign do_value  = do_q[rd_thread];
    assign po_value  = po_q[rd_thread][rd_index];
    assign inc_value = inc_q[rd_thread][rd_index];

endmodule

`default_nettype wire

// ==== rtl/addressing_map.sv ====
// Memory map decode of A/B read windows and of ALU writes to the offset tables

`timescale 1ns/1ns
`default_nettype none

module addressing_map import addressing_pkg::*; #(
    parameter  int       THREAD_COUNT    = 4,
    parameter  int       PO_COUNT        = 4,
    parameter  addr_t    PO_READ_BASE    = 10'h3F0,
    parameter  addr_t    IO_READ_BASE    = 10'h3F8,
    parameter  int       IO_COUNT        = 4,
    parameter  wr_addr_t DO_WRITE_ADDR   = 12'h800,
    parameter  wr_addr_t PO_WRITE_BASE   = 12'h810,
    parameter  wr_addr_t INC_WRITE_BASE  = 12'h820,
    parameter  int       PO_WORD_OFFSET  = 0,
    parameter  int       INC_WORD_OFFSET = 16,
    parameter  int       DO_WORD_OFFSET  = 0,
    localparam int       THREAD_W        = (THREAD_COUNT > 1) ? $clog2(THREAD_COUNT) : 1,
    localparam int       SLOT_W          = (PO_COUNT > 1) ? $clog2(PO_COUNT) : 1
) (
    input  wire                 clock,
    input  wire                 arst_n,

    // Read address from the previous pipeline stage
    input  wire addr_t          addr_in,

    // ALU result and its destination
    input  wire wr_addr_t       alu_write_addr,
    input  wire word_t          alu_write_data,
    input  wire [THREAD_W-1:0]  alu_wr_thread,

    // Read window hits, one cycle after addr_in
    output logic                hit_indirect,
    output logic                hit_io,
    output logic [SLOT_W-1:0]   po_index,

    offset_write_if.src         wr
);

    // --------------------
    // Read windows

    // Distance from each window base, wraps when addr_in sits below it
    addr_t po_distance;
    addr_t io_distance;
    logic  in_po_window;
    logic  in_io_window;

    assign po_distance  = addr_in - PO_READ_BASE;
    assign io_distance  = addr_in - IO_READ_BASE;
    assign in_po_window = (addr_in >= PO_READ_BASE) && (po_distance < addr_t'(PO_COUNT));
    assign in_io_window = (addr_in >= IO_READ_BASE) && (io_distance < addr_t'(IO_COUNT));

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            hit_indirect <= 1'b0;
            hit_io       <= 1'b0;
        end else begin
            hit_indirect <= in_po_window;
            hit_io       <= in_io_window;
        end
    end

    // Slot number within the indirect window, only meaningful on a hit
    always_ff @(posedge clock) begin
        po_index <= po_distance[SLOT_W-1:0];
    end

    // --------------------
    // ALU write decode

    // One default offset per thread, so a single address covers all of them
    assign wr.wren_do = (alu_write_addr == DO_WRITE_ADDR);

    // Slot i of each table sits at its base plus i
    always_comb begin
        for (int i = 0; i < PO_COUNT; i++) begin
            wr.wren_po[i]  = (alu_write_addr == wr_addr_t'(PO_WRITE_BASE + i));
            wr.wren_inc[i] = (alu_write_addr == wr_addr_t'(INC_WRITE_BASE + i));
        end
    end

    assign wr.wr_thread = alu_wr_thread;

    // Fields sit at fixed bit offsets, so PO and INC can share one ALU word
    assign wr.do_data  = alu_write_data[DO_WORD_OFFSET +: OFFSET_WIDTH];
    assign wr.po_data  = alu_write_data[PO_WORD_OFFSET +: OFFSET_WIDTH];
    assign wr.inc_data = alu_write_data[INC_WORD_OFFSET +: INC_WIDTH];

endmodule

`default_nettype wire

// ==== rtl/offset_write_if.sv ====
// Decoded ALU writes from the memory map decoder into the per-thread offset tables

`timescale 1ns/1ns
`default_nettype none

interface offset_write_if import addressing_pkg::*; #(
    parameter  int THREAD_COUNT = 4,
    parameter  int PO_COUNT     = 4,
    localparam int THREAD_W     = (THREAD_COUNT > 1) ? $clog2(THREAD_COUNT) : 1
);

    // One strobe at most is high in any cycle
    logic                wren_do;
    logic [PO_COUNT-1:0] wren_po;
    logic [PO_COUNT-1:0] wren_inc;

    // Target thread and the fields already sliced out of the ALU word
    logic [THREAD_W-1:0] wr_thread;
    offset_t             do_data;
    offset_t             po_data;
    increment_t          inc_data;

    modport src (
        output wren_do, wren_po, wren_inc, wr_thread, do_data, po_data, inc_data
    );

    modport dst (
        input  wren_do, wren_po, wren_inc, wr_thread, do_data, po_data, inc_data
    );

endinterface

`default_nettype wire

// ==== rtl/addressing_pkg.sv ====
// Operand addressing shared widths, vector types and the offset kind encoding

`default_nettype none

package addressing_pkg;

    // --------------------
    // Architectural widths

    // ALU result word
    localparam int WORD_WIDTH      = 36;

    // A/B memory read address
    localparam int ADDR_WIDTH      = 10;

    // ALU destination operand, which is the write address space
    localparam int D_OPERAND_WIDTH = 12;

    // Offsets wrap within the read address space
    localparam int OFFSET_WIDTH    = ADDR_WIDTH;
    localparam int INC_WIDTH       = 4;

    // --------------------
    // Vector types

    typedef logic [WORD_WIDTH-1:0]      word_t;
    typedef logic [ADDR_WIDTH-1:0]      addr_t;
    typedef logic [D_OPERAND_WIDTH-1:0] wr_addr_t;
    typedef logic [OFFSET_WIDTH-1:0]    offset_t;

    // Two's complement, sign extended to OFFSET_WIDTH before the add
    typedef logic [INC_WIDTH-1:0]       increment_t;

    // How a read address gets translated in stage 2
    typedef enum logic [1:0] {
        kind_default,
        kind_indirect,
        kind_shared
    } offset_kind_e;

endpackage

`default_nettype wire
